// File: all.f
+incdir+logic
logic/rd_pkg.sv
logic/rd_arbiter.sv
logic/axi_rd_master.sv
logic/rd_mem.sv
logic/rd_subsys_top.sv
verification/tb_clkgen.sv
verification/tb_rd_subsys.sv

// File: logic/axi_rd_master.sv
`timescale 1ns/1ns
`include "rd_defs.svh"

module axi_rd_master import rd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // request from arbiter
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic [`RD_ADDR_W-1:0] req_addr_i,
    input  rd_size_e              req_size_i,
    // response to arbiter
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output logic [`RD_DATA_W-1:0] rsp_data_o,
    // read address channel
    output logic                  ar_valid_o,
    input  logic                  ar_ready_i,
    output logic [`RD_ADDR_W-1:0] ar_addr_o,
    // read data channel
    input  logic                  r_valid_i,
    output logic                  r_ready_o,
    input  logic [`RD_DATA_W-1:0] r_data_i
);

    mst_state_e            state_q;
    logic [`RD_ADDR_W-1:0] addr_q;      // byte address of current read
    rd_size_e              size_q;
    logic [`RD_DATA_W-1:0] data_q;      // aligned result
    logic [`RD_OFF_W-1:0]  off_b;       // byte offset rounded to size
    logic [`RD_DATA_W-1:0] shifted;
    logic [`RD_DATA_W-1:0] aligned;

    // handshake outputs straight from state
    assign req_ready_o = (state_q == MST_IDLE);
    assign ar_valid_o  = (state_q == MST_AR);
    assign r_ready_o   = (state_q == MST_R);
    assign rsp_valid_o = (state_q == MST_RSP);
    assign rsp_data_o  = data_q;

    // word aligned address phase
    assign ar_addr_o = {addr_q[`RD_ADDR_W-1:`RD_OFF_W], {`RD_OFF_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= MST_IDLE;
        end else begin
            case (state_q)
                MST_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= MST_AR;
                    end
                end
                MST_AR: begin
                    if (ar_ready_i) begin
                        state_q <= MST_R;
                    end
                end
                MST_R: begin
                    if (r_valid_i) begin
                        state_q <= MST_RSP;
                    end
                end
                MST_RSP: begin
                    if (rsp_ready_i) begin
                        state_q <= MST_IDLE;    // back-pressure holds data_q
                    end
                end
                default: state_q <= MST_IDLE;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            addr_q <= req_addr_i;
            size_q <= req_size_i;
        end
        if (r_valid_i && r_ready_o) begin
            data_q <= aligned;
        end
    end

    // misaligned low bits dropped
    always_comb begin
        off_b = addr_q[`RD_OFF_W-1:0];
        case (size_q)
            SZ_H: off_b[0] = 1'b0;
            SZ_W: off_b[1:0] = 2'b00;
            SZ_B: ;
            default: off_b = '0;    // full word
        endcase
    end

    assign shifted = r_data_i >> {off_b, 3'b000};    // bytes down to bit 0

    // zero extend by size
    always_comb begin
        aligned = '0;
        case (size_q)
            SZ_B: aligned[7:0] = shifted[7:0];
            SZ_H: aligned[15:0] = shifted[15:0];
            SZ_W: aligned[31:0] = shifted[31:0];
            default: aligned = shifted;
        endcase
    end

    // address phase holds until the memory takes it
    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

endmodule

// File: logic/rd_arbiter.sv
`timescale 1ns/1ns
`include "rd_defs.svh"

module rd_arbiter import rd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // data port wins a tie
    input  logic                  mem_req_valid_i,
    output logic                  mem_req_ready_o,
    input  logic [`RD_ADDR_W-1:0] mem_req_addr_i,
    input  rd_size_e              mem_req_size_i,
    output logic                  mem_rsp_valid_o,
    input  logic                  mem_rsp_ready_i,
    output logic [`RD_DATA_W-1:0] mem_rsp_data_o,
    // fetch port
    input  logic                  if_req_valid_i,
    output logic                  if_req_ready_o,
    input  logic [`RD_ADDR_W-1:0] if_req_addr_i,
    input  rd_size_e              if_req_size_i,
    output logic                  if_rsp_valid_o,
    input  logic                  if_rsp_ready_i,
    output logic [`RD_DATA_W-1:0] if_rsp_data_o,
    // shared downstream port
    output logic                  dn_req_valid_o,
    input  logic                  dn_req_ready_i,
    output logic [`RD_ADDR_W-1:0] dn_req_addr_o,
    output rd_size_e              dn_req_size_o,
    input  logic                  dn_rsp_valid_i,
    output logic                  dn_rsp_ready_o,
    input  logic [`RD_DATA_W-1:0] dn_rsp_data_i
);

    arb_state_e state_q;
    arb_state_e state_d;
    logic       mem_sel;    // data port granted
    logic       if_sel;     // fetch port granted
    logic       rsp_hs;     // downstream response taken

    assign mem_sel = (state_q == ARB_MEM);
    assign if_sel  = (state_q == ARB_IF);
    assign rsp_hs  = dn_rsp_valid_i & dn_rsp_ready_o;

    // grant only from idle and release after the response handshake
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (mem_req_valid_i) begin
                    state_d = ARB_MEM;    // data port first
                end else if (if_req_valid_i) begin
                    state_d = ARB_IF;
                end
            end
            ARB_MEM, ARB_IF: begin
                if (rsp_hs) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // request side steering
    assign dn_req_valid_o = (mem_sel & mem_req_valid_i) | (if_sel & if_req_valid_i);
    assign dn_req_addr_o  = mem_sel ? mem_req_addr_i : (if_sel ? if_req_addr_i : '0);
    assign dn_req_size_o  = mem_sel ? mem_req_size_i : (if_sel ? if_req_size_i : SZ_B);
    assign mem_req_ready_o = mem_sel & dn_req_ready_i;    // loser sees ready low
    assign if_req_ready_o  = if_sel & dn_req_ready_i;

    // response side steering
    assign mem_rsp_valid_o = mem_sel & dn_rsp_valid_i;
    assign if_rsp_valid_o  = if_sel & dn_rsp_valid_i;
    assign dn_rsp_ready_o  = (mem_sel & mem_rsp_ready_i) | (if_sel & if_rsp_ready_i);
    assign mem_rsp_data_o  = mem_sel ? dn_rsp_data_i : '0;
    assign if_rsp_data_o   = if_sel ? dn_rsp_data_i : '0;

    // no downstream read left in flight once the grant is gone
    a_grant_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        state_q == ARB_IDLE |-> dn_req_ready_i);

    // each downstream response reaches exactly one port
    a_rsp_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        dn_rsp_valid_i |-> mem_rsp_valid_o != if_rsp_valid_o);

endmodule

// File: logic/rd_defs.svh
`ifndef RD_DEFS_SVH
`define RD_DEFS_SVH

// byte address width seen by both requesters
`define RD_ADDR_W 32

// one memory word per beat
`define RD_DATA_W 64

// number of words in rd_mem
`define RD_MEM_DEPTH 256

// cycles from AR handshake to r_valid
// keep at 2 or more for the rd_mem countdown
`define RD_MEM_LAT 3

// byte offset bits within one data word
`define RD_OFF_W 3

// word index bits for the backdoor port
`define RD_IDX_W 8

`endif

// File: logic/rd_mem.sv
`timescale 1ns/1ns
`include "rd_defs.svh"

module rd_mem (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // read address channel
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    input  logic [`RD_ADDR_W-1:0] ar_addr_i,
    // read data channel
    output logic                  r_valid_o,
    input  logic                  r_ready_i,
    output logic [`RD_DATA_W-1:0] r_data_o,
    // backdoor preload
    input  logic                  wr_en_i,
    input  logic [`RD_IDX_W-1:0]  wr_addr_i,    // word index
    input  logic [`RD_DATA_W-1:0] wr_data_i
);

    localparam int CNT_W = $clog2(`RD_MEM_LAT + 1);

    logic [`RD_DATA_W-1:0] mem_q [`RD_MEM_DEPTH];
    logic                  busy_q;      // read in flight
    logic                  r_valid_q;
    logic [CNT_W-1:0]      cnt_q;       // edges left before data
    logic [`RD_IDX_W-1:0]  idx_q;       // latched word index
    logic [`RD_DATA_W-1:0] r_data_q;
    logic                  ar_hs;
    logic                  r_hs;
    logic                  present;     // last countdown edge

    assign ar_ready_o = ~busy_q;    // one read at a time
    assign ar_hs      = ar_valid_i & ar_ready_o;
    assign r_hs       = r_valid_q & r_ready_i;
    assign present    = busy_q & ~r_valid_q & (cnt_q == CNT_W'(1));
    assign r_valid_o  = r_valid_q;
    assign r_data_o   = r_data_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            r_valid_q <= 1'b0;
            cnt_q     <= '0;
        end else begin
            if (ar_hs) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(`RD_MEM_LAT - 1);
            end else if (present) begin
                r_valid_q <= 1'b1;    // lands RD_MEM_LAT after AR
                cnt_q     <= '0;
            end else if (busy_q && !r_valid_q) begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
            if (r_hs) begin
                r_valid_q <= 1'b0;
                busy_q    <= 1'b0;    // ar_ready back next cycle
            end
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
        if (ar_hs) begin
            idx_q <= ar_addr_i[`RD_OFF_W +: `RD_IDX_W];    // upper bits wrap
        end
        if (present) begin
            r_data_q <= mem_q[idx_q];
        end
    end

    // fixed latency from address to data
    a_lat: assert property (@(posedge clk) disable iff (!rst_n_i)
        ar_hs |-> ##(`RD_MEM_LAT) r_valid_o);

    // data held under back-pressure
    a_r_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o));

endmodule

// File: logic/rd_pkg.sv
package rd_pkg;

    // access size in AXI arsize encoding
    typedef enum logic [2:0] {
        SZ_B = 3'd0,    // 1 byte
        SZ_H = 3'd1,    // 2 bytes
        SZ_W = 3'd2,    // 4 bytes
        SZ_D = 3'd3     // 8 bytes, full word
    } rd_size_e;

    // arbiter grant
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,    // no grant
        ARB_MEM  = 2'd1,    // data port owns downstream
        ARB_IF   = 2'd2     // fetch port owns downstream
    } arb_state_e;

    // bus master sequence
    typedef enum logic [1:0] {
        MST_IDLE = 2'd0,    // ready for a request
        MST_AR   = 2'd1,    // address phase
        MST_R    = 2'd2,    // waiting on read data
        MST_RSP  = 2'd3     // aligned data out
    } mst_state_e;

endpackage

// File: logic/rd_subsys_top.sv
`timescale 1ns/1ns
`include "rd_defs.svh"

module rd_subsys_top import rd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // data port
    input  logic                  mem_req_valid_i,
    output logic                  mem_req_ready_o,
    input  logic [`RD_ADDR_W-1:0] mem_req_addr_i,
    input  rd_size_e              mem_req_size_i,
    output logic                  mem_rsp_valid_o,
    input  logic                  mem_rsp_ready_i,
    output logic [`RD_DATA_W-1:0] mem_rsp_data_o,
    // fetch port
    input  logic                  if_req_valid_i,
    output logic                  if_req_ready_o,
    input  logic [`RD_ADDR_W-1:0] if_req_addr_i,
    input  rd_size_e              if_req_size_i,
    output logic                  if_rsp_valid_o,
    input  logic                  if_rsp_ready_i,
    output logic [`RD_DATA_W-1:0] if_rsp_data_o,
    // memory preload
    input  logic                  wr_en_i,
    input  logic [`RD_IDX_W-1:0]  wr_addr_i,
    input  logic [`RD_DATA_W-1:0] wr_data_i
);

    // arbiter to master
    logic                  dn_req_valid;
    logic                  dn_req_ready;
    logic [`RD_ADDR_W-1:0] dn_req_addr;
    rd_size_e              dn_req_size;
    logic                  dn_rsp_valid;
    logic                  dn_rsp_ready;
    logic [`RD_DATA_W-1:0] dn_rsp_data;

    // master to memory
    logic                  ar_valid;
    logic                  ar_ready;
    logic [`RD_ADDR_W-1:0] ar_addr;
    logic                  r_valid;
    logic                  r_ready;
    logic [`RD_DATA_W-1:0] r_data;

    rd_arbiter u_rd_arbiter (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .mem_req_valid_i (mem_req_valid_i),
        .mem_req_ready_o (mem_req_ready_o),
        .mem_req_addr_i  (mem_req_addr_i),
        .mem_req_size_i  (mem_req_size_i),
        .mem_rsp_valid_o (mem_rsp_valid_o),
        .mem_rsp_ready_i (mem_rsp_ready_i),
        .mem_rsp_data_o  (mem_rsp_data_o),
        .if_req_valid_i  (if_req_valid_i),
        .if_req_ready_o  (if_req_ready_o),
        .if_req_addr_i   (if_req_addr_i),
        .if_req_size_i   (if_req_size_i),
        .if_rsp_valid_o  (if_rsp_valid_o),
        .if_rsp_ready_i  (if_rsp_ready_i),
        .if_rsp_data_o   (if_rsp_data_o),
        .dn_req_valid_o  (dn_req_valid),
        .dn_req_ready_i  (dn_req_ready),
        .dn_req_addr_o   (dn_req_addr),
        .dn_req_size_o   (dn_req_size),
        .dn_rsp_valid_i  (dn_rsp_valid),
        .dn_rsp_ready_o  (dn_rsp_ready),
        .dn_rsp_data_i   (dn_rsp_data)
    );

    axi_rd_master u_axi_rd_master (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (dn_req_valid),
        .req_ready_o (dn_req_ready),
        .req_addr_i  (dn_req_addr),
        .req_size_i  (dn_req_size),
        .rsp_valid_o (dn_rsp_valid),
        .rsp_ready_i (dn_rsp_ready),
        .rsp_data_o  (dn_rsp_data),
        .ar_valid_o  (ar_valid),
        .ar_ready_i  (ar_ready),
        .ar_addr_o   (ar_addr),
        .r_valid_i   (r_valid),
        .r_ready_o   (r_ready),
        .r_data_i    (r_data)
    );

    rd_mem u_rd_mem (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_addr_i  (ar_addr),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_data_o   (r_data),
        .wr_en_i    (wr_en_i),
        .wr_addr_i  (wr_addr_i),
        .wr_data_i  (wr_data_i)
    );

endmodule

// File: run.sh
#!/usr/bin/env bash
# exit status follows the simulation, any $fatal makes it nonzero
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
    --top-module tb_rd_subsys -f all.f \
    && ./obj_dir/Vtb_rd_subsys \
    || { echo "simulation failed"; exit 1; }

// File: verification/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // first rising edge at half a period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

endmodule

// File: verification/tb_rd_subsys.sv
`timescale 1ns/1ns
`include "rd_defs.svh"

module tb_rd_subsys import rd_pkg::*; ();

    localparam int N_SIZE   = 64;     // 2 ports x 4 sizes x 8 offsets
    localparam int N_PRIO   = 4;      // tie pairs
    localparam int N_RAND   = 400;
    localparam int N_READS  = N_SIZE + 2 * N_PRIO + N_RAND;
    localparam int LIMIT_NS = N_READS * (`RD_MEM_LAT + 12 + 4) * 4 * 2;
    localparam int IDX_W    = `RD_IDX_W;

    logic                  clk;
    logic                  rst_n;
    logic                  mem_req_valid;
    logic                  mem_req_ready;
    logic [`RD_ADDR_W-1:0] mem_req_addr;
    rd_size_e              mem_req_size;
    logic                  mem_rsp_valid;
    logic                  mem_rsp_ready;
    logic [`RD_DATA_W-1:0] mem_rsp_data;
    logic                  if_req_valid;
    logic                  if_req_ready;
    logic [`RD_ADDR_W-1:0] if_req_addr;
    rd_size_e              if_req_size;
    logic                  if_rsp_valid;
    logic                  if_rsp_ready;
    logic [`RD_DATA_W-1:0] if_rsp_data;
    logic                  wr_en;
    logic [IDX_W-1:0]      wr_addr;
    logic [`RD_DATA_W-1:0] wr_data;

    integer                seed;
    logic [`RD_DATA_W-1:0] model_mem [$];    // copy of preloaded words
    logic [`RD_DATA_W-1:0] exp_mem_q [$];    // expected per port in order
    logic [`RD_DATA_W-1:0] exp_if_q [$];
    bit                    rnd_port_q [$];
    logic [`RD_ADDR_W-1:0] rnd_addr_q [$];
    rd_size_e              rnd_size_q [$];
    int                    rnd_gap_q [$];
    int                    stall_mem_q [$];  // rsp_ready low cycles
    int                    stall_if_q [$];
    time                   t_mem_rsp;
    time                   t_if_req;
    time                   t_if_rsp;
    int                    rsp_cnt;

    tb_clkgen #(.PERIOD_NS(4)) u_tb_clkgen (.clk_o(clk));

    rd_subsys_top u_rd_subsys_top (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_o (mem_req_ready),
        .mem_req_addr_i  (mem_req_addr),
        .mem_req_size_i  (mem_req_size),
        .mem_rsp_valid_o (mem_rsp_valid),
        .mem_rsp_ready_i (mem_rsp_ready),
        .mem_rsp_data_o  (mem_rsp_data),
        .if_req_valid_i  (if_req_valid),
        .if_req_ready_o  (if_req_ready),
        .if_req_addr_i   (if_req_addr),
        .if_req_size_i   (if_req_size),
        .if_rsp_valid_o  (if_rsp_valid),
        .if_rsp_ready_i  (if_rsp_ready),
        .if_rsp_data_o   (if_rsp_data),
        .wr_en_i         (wr_en),
        .wr_addr_i       (wr_addr),
        .wr_data_i       (wr_data)
    );

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // word at addr bits above 3 shifted by the size-aligned offset and masked
    function automatic logic [63:0] model_read(input logic [31:0] addr, input rd_size_e size);
        int          nbytes;
        int          off;
        int          idx;
        logic [63:0] word;
        logic [63:0] mask;
        nbytes = 1 << int'(size);
        idx    = int'((addr >> 3) % `RD_MEM_DEPTH);
        off    = int'(addr[2:0]);
        off    = off - (off % nbytes);
        word   = model_mem[idx] >> (8 * off);
        if (nbytes == 8) begin
            mask = '1;
        end else begin
            mask = (64'd1 << (8 * nbytes)) - 64'd1;
        end
        return word & mask;
    endfunction

    // called and returns 1 ns after a rising edge
    task automatic send_req(input bit port, input logic [31:0] addr, input rd_size_e size);
        if (port == 1'b0) begin
            mem_req_valid = 1'b1;
            mem_req_addr  = addr;
            mem_req_size  = size;
            do @(negedge clk); while (!mem_req_ready);    // held until taken
            @(posedge clk);
            #1;
            mem_req_valid = 1'b0;
        end else begin
            if_req_valid = 1'b1;
            if_req_addr  = addr;
            if_req_size  = size;
            do @(negedge clk); while (!if_req_ready);
            @(posedge clk);
            #1;
            if_req_valid = 1'b0;
        end
    endtask

    // until every accepted read has its response and the arbiter is idle
    task automatic wait_idle();
        while (exp_mem_q.size() != 0 || exp_if_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_port(input bit port);
        for (int i = 0; i < N_RAND; i++) begin
            if (rnd_port_q[i] == port) begin
                repeat (rnd_gap_q[i]) begin
                    @(posedge clk);
                    #1;
                end
                send_req(port, rnd_addr_q[i], rnd_size_q[i]);
            end
        end
    endtask

    // rsp_ready for both ports with stall counts from the tables
    initial begin : rsp_ready_drive
        int mem_wait;
        int if_wait;
        int mem_n;
        int if_n;
        mem_rsp_ready = 1'b0;
        if_rsp_ready  = 1'b0;
        mem_wait = 0;
        if_wait  = 0;
        mem_n    = 0;
        if_n     = 0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_rsp_ready) begin
                mem_rsp_ready = 1'b0;    // handshake on this edge
                mem_n++;
            end else if (mem_rsp_valid) begin
                if (mem_wait == 0) mem_rsp_ready = 1'b1;
                else mem_wait--;
            end else begin
                mem_wait = stall_mem_q[mem_n % N_READS];
            end
            if (if_rsp_ready) begin
                if_rsp_ready = 1'b0;
                if_n++;
            end else if (if_rsp_valid) begin
                if (if_wait == 0) if_rsp_ready = 1'b1;
                else if_wait--;
            end else begin
                if_wait = stall_if_q[if_n % N_READS];
            end
        end
    end

    // sampled mid cycle while inputs are settled
    always @(negedge clk) begin : bus_monitor
        logic                  mem_hold;
        logic                  if_hold;
        logic [`RD_DATA_W-1:0] mem_hold_data;
        logic [`RD_DATA_W-1:0] if_hold_data;
        logic [`RD_DATA_W-1:0] exp;
        if (rst_n) begin
            if (mem_hold) begin    // back-pressure last cycle
                check_eq({63'd0, mem_rsp_valid}, 64'd1, "data port rsp_valid dropped early");
                check_eq(mem_rsp_data, mem_hold_data, "data port rsp_data moved while stalled");
            end
            if (if_hold) begin
                check_eq({63'd0, if_rsp_valid}, 64'd1, "fetch port rsp_valid dropped early");
                check_eq(if_rsp_data, if_hold_data, "fetch port rsp_data moved while stalled");
            end
            if (mem_req_valid && mem_req_ready) begin
                exp_mem_q.push_back(model_read(mem_req_addr, mem_req_size));
            end
            if (if_req_valid && if_req_ready) begin
                exp_if_q.push_back(model_read(if_req_addr, if_req_size));
                t_if_req = $time;
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                if (exp_mem_q.size() == 0) begin
                    $display("data port got a response at %0t ns with no read outstanding", $time);
                    abort_run();
                end else begin
                    exp = exp_mem_q.pop_front();
                    check_eq(mem_rsp_data, exp, "data port rsp_data");
                    t_mem_rsp = $time;
                    rsp_cnt++;
                end
            end
            if (if_rsp_valid && if_rsp_ready) begin
                if (exp_if_q.size() == 0) begin
                    $display("fetch port got a response at %0t ns with no read outstanding", $time);
                    abort_run();
                end else begin
                    exp = exp_if_q.pop_front();
                    check_eq(if_rsp_data, exp, "fetch port rsp_data");
                    t_if_rsp = $time;
                    rsp_cnt++;
                end
            end
        end
        mem_hold      = rst_n && mem_rsp_valid && !mem_rsp_ready;
        if_hold       = rst_n && if_rsp_valid && !if_rsp_ready;
        mem_hold_data = mem_rsp_data;
        if_hold_data  = if_rsp_data;
    end

    initial begin : watchdog
        #(LIMIT_NS);
        $display("timeout: %0d reads did not finish within %0d ns", N_READS, LIMIT_NS);
        abort_run();
    end

    initial begin : main
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] addr;
        rst_n         = 1'b0;
        mem_req_valid = 1'b0;
        mem_req_addr  = '0;
        mem_req_size  = SZ_B;
        if_req_valid  = 1'b0;
        if_req_addr   = '0;
        if_req_size   = SZ_B;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        rsp_cnt       = 0;
        seed          = 23546;
        // all random values drawn up front from one process
        for (int i = 0; i < `RD_MEM_DEPTH; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            model_mem.push_back({r, r2});
        end
        for (int i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            rnd_port_q.push_back(r[0]);
            rnd_size_q.push_back(rd_size_e'({1'b0, r[2:1]}));
            rnd_gap_q.push_back(int'(r[4:3]));    // 0 to 3 idle cycles
            rnd_addr_q.push_back($random(seed));
        end
        for (int i = 0; i < N_READS; i++) begin
            r = $random(seed);
            stall_mem_q.push_back(int'($unsigned(r) % 5));
            r = $random(seed);
            stall_if_q.push_back(int'($unsigned(r) % 5));
        end

        repeat (16) begin
            @(posedge clk);
            #1;
            check_eq({60'd0, mem_req_ready, if_req_ready, mem_rsp_valid, if_rsp_valid}, 64'd0,
                "handshake outputs during reset");
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_eq({60'd0, mem_req_ready, if_req_ready, mem_rsp_valid, if_rsp_valid}, 64'd0,
            "handshake outputs after reset");

        for (int i = 0; i < `RD_MEM_DEPTH; i++) begin    // backdoor preload
            wr_en   = 1'b1;
            wr_addr = IDX_W'(i);
            wr_data = model_mem[i];
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;

        // every size at every byte offset with upper address bits set
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < 4; s++) begin
                for (int o = 0; o < 8; o++) begin
                    addr = (32'(p) << 24) | (32'(s * 8 + o + p * 32) << 3) | 32'(o);
                    send_req(p[0], addr, rd_size_e'(s[2:0]));
                    wait_idle();
                end
            end
        end

        // same-cycle requests where the data port goes first
        for (int k = 0; k < N_PRIO; k++) begin
            fork
                send_req(1'b0, 32'(k * 72 + 3), rd_size_e'(3'(k)));
                send_req(1'b1, 32'(k * 40 + 4), SZ_W);
            join
            wait_idle();
            check_eq(64'(t_if_rsp > t_mem_rsp), 64'd1, "fetch response before data response");
            check_eq(64'(t_if_req > t_mem_rsp), 64'd1, "fetch request taken before data response");
        end

        fork
            run_port(1'b0);
            run_port(1'b1);
        join
        wait_idle();
        check_eq(64'(rsp_cnt), 64'(N_READS), "response count");

        $display("PASS: all tests");
        $finish;
    end

endmodule
